// File: filelist.f
source/tlb_pkg.sv
source/tlb_wr_if.sv
source/tlb_miss_if.sv
source/tlb_way_ram.sv
source/tlb_write_port.sv
source/tlb_lookup.sv
source/tlb_miss_queue.sv
source/tlb_top.sv
verif/tb_clk_gen.sv
verif/tb_tlb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TLB testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tlb -f filelist.f -o sim_tlb

status=0
./obj_dir/sim_tlb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "TESTS PASSED" sim.log
exit "$status"

// File: source/tlb_lookup.sv
`timescale 1ns/1ns
`default_nettype none

// One address-generation lookup. Both ways are read at the set index, the
// hit is registered for one cycle and a miss is reported on the same cycle
module tlb_lookup #(parameter int TLB_ENTRIES = 128) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           v_i,
  input  tlb_pkg::address_t              vadr_i,
  input  tlb_pkg::asid_t                 asid_i,
  input  tlb_pkg::rob_ndx_t              rndx_i,
  input  logic                           stall_i,
  output logic [$clog2(TLB_ENTRIES)-1:0] idx_o,
  input  tlb_pkg::tlb_entry_t            way0_entry_i,
  input  tlb_pkg::tlb_entry_t            way1_entry_i,
  tlb_miss_if.src                        miss,
  output logic                           v_o,
  output tlb_pkg::tlb_entry_t            entry_o,
  output tlb_pkg::address_t              vadr_o,
  output tlb_pkg::rob_ndx_t              rndx_o
);
  import tlb_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRIES);

  vpn_t       vpn;
  logic       hit0;
  logic       hit1;
  logic       take;      // Request accepted this cycle
  tlb_entry_t hit_entry;

  assign idx_o = vadr_i[PAGE_SHIFT +: IDX_W];      // Set index above the page offset
  assign vpn   = vadr_i[ADDR_W-1:PAGE_SHIFT];      // Full page number is compared

  assign hit0 = way0_entry_i.valid && (way0_entry_i.vpn == vpn) && (way0_entry_i.asid == asid_i);
  assign hit1 = way1_entry_i.valid && (way1_entry_i.vpn == vpn) && (way1_entry_i.asid == asid_i);

  assign hit_entry = hit0 ? way0_entry_i : way1_entry_i;   // Way 0 has priority
  assign take      = v_i && !stall_i;

  // Miss report goes straight to the queue
  assign miss.miss = take && !(hit0 || hit1);
  assign miss.vadr = vadr_i;
  assign miss.asid = asid_i;
  assign miss.rndx = rndx_i;

  always_ff @(posedge clk) begin
    if (rst) v_o <= 1'b0;
    else     v_o <= take && (hit0 || hit1);        // One pulse per accepted hit
  end

  always_ff @(posedge clk) begin
    if (take && (hit0 || hit1)) begin
      entry_o <= hit_entry;
      vadr_o  <= vadr_i;
      rndx_o  <= rndx_i;
    end
  end

  // A stalled cycle never produces a result one cycle later
  a_stall_no_v: assert property (@(posedge clk) disable iff (rst) stall_i |=> !v_o);

endmodule

`default_nettype wire

// File: source/tlb_miss_if.sv
`timescale 1ns/1ns
`default_nettype none

// Miss report of one lookup port, valid only in the current cycle
interface tlb_miss_if;
  import tlb_pkg::*;

  logic     miss;   // Accepted request found no matching entry
  address_t vadr;
  asid_t    asid;
  rob_ndx_t rndx;   // Reorder-buffer slot waiting on the walk

  modport src  (output miss, vadr, asid, rndx);
  modport sink (input miss, vadr, asid, rndx);

endinterface

`default_nettype wire

// File: source/tlb_miss_queue.sv
`timescale 1ns/1ns
`default_nettype none

// Circular queue of outstanding misses. Takes up to two misses a cycle in
// port order, filters pages already waiting and shows the oldest to the walker
module tlb_miss_queue #(parameter int MISSQ_ENTRIES = 16) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ready_i,
  tlb_miss_if.sink           m0,
  tlb_miss_if.sink           m1,
  input  logic               missack_i,
  output logic               miss_o,
  output tlb_pkg::miss_src_e miss_src_o,
  output tlb_pkg::address_t  miss_vadr_o,
  output tlb_pkg::asid_t     miss_asid_o,
  output tlb_pkg::rob_ndx_t  miss_rndx_o
);
  import tlb_pkg::*;

  localparam int PTR_W = $clog2(MISSQ_ENTRIES);   // Pointers wrap, depth is a power of two
  localparam int CNT_W = PTR_W + 1;

  miss_src_e              q_src  [MISSQ_ENTRIES];
  address_t               q_vadr [MISSQ_ENTRIES];
  asid_t                  q_asid [MISSQ_ENTRIES];
  rob_ndx_t               q_rndx [MISSQ_ENTRIES];
  logic [MISSQ_ENTRIES-1:0] q_vld;                // Slot holds a waiting miss
  logic [PTR_W-1:0]       head;
  logic [PTR_W-1:0]       tail;
  logic [PTR_W-1:0]       tail_nxt;               // Slot for port 1
  logic [CNT_W-1:0]       count;
  vpn_t                   vpn0;
  vpn_t                   vpn1;
  logic                   room;
  logic                   in_q0;
  logic                   in_q1;
  logic                   same_pg;
  logic                   en0;
  logic                   en1;
  logic                   pop;

  // ==========================================================================
  // Enqueue decision
  // ==========================================================================
  assign vpn0 = m0.vadr[ADDR_W-1:PAGE_SHIFT];
  assign vpn1 = m1.vadr[ADDR_W-1:PAGE_SHIFT];

  always_comb begin
    in_q0 = 1'b0;
    in_q1 = 1'b0;
    for (int i = 0; i < MISSQ_ENTRIES; i++) begin
      if (q_vld[i] && (q_vadr[i][ADDR_W-1:PAGE_SHIFT] == vpn0) && (q_asid[i] == m0.asid))
        in_q0 = 1'b1;
      if (q_vld[i] && (q_vadr[i][ADDR_W-1:PAGE_SHIFT] == vpn1) && (q_asid[i] == m1.asid))
        in_q1 = 1'b1;
    end
  end

  // Both ports may land in one cycle, so two places must be free
  assign room    = (count <= CNT_W'(MISSQ_ENTRIES - 3));
  assign same_pg = m0.miss && (vpn0 == vpn1) && (m0.asid == m1.asid);
  assign en0     = ready_i && room && m0.miss && !in_q0;
  assign en1     = ready_i && room && m1.miss && !in_q1 && !same_pg;   // Port 0 wins a tie
  assign pop     = missack_i && miss_o;
  assign tail_nxt = tail + PTR_W'(en0);

  // ==========================================================================
  // Pointers and storage
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      q_vld <= '0;
    end else begin
      if (pop) begin
        q_vld[head] <= 1'b0;
        head        <= head + 1'b1;
      end
      if (en0) q_vld[tail]     <= 1'b1;
      if (en1) q_vld[tail_nxt] <= 1'b1;
      tail  <= tail + PTR_W'(en0) + PTR_W'(en1);
      count <= count + CNT_W'(en0) + CNT_W'(en1) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (en0) begin
      q_src[tail]  <= MISS_AGEN0;
      q_vadr[tail] <= m0.vadr;
      q_asid[tail] <= m0.asid;
      q_rndx[tail] <= m0.rndx;
    end
    if (en1) begin
      q_src[tail_nxt]  <= MISS_AGEN1;
      q_vadr[tail_nxt] <= m1.vadr;
      q_asid[tail_nxt] <= m1.asid;
      q_rndx[tail_nxt] <= m1.rndx;
    end
  end

  // Oldest miss is held as a level until the walker acknowledges it
  assign miss_o      = (count != '0);
  assign miss_src_o  = q_src[head];
  assign miss_vadr_o = q_vadr[head];
  assign miss_asid_o = q_asid[head];
  assign miss_rndx_o = q_rndx[head];

  a_ack_when_miss: assert property (@(posedge clk) disable iff (rst) missack_i |-> miss_o);
  a_count_cap: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(MISSQ_ENTRIES - 1));

endmodule

`default_nettype wire

// File: source/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

  // ==========================================================================
  // Address and field widths
  // ==========================================================================
  localparam int ADDR_W     = 32;
  localparam int PAGE_SHIFT = 16;       // 64 kB pages, set index sits just above
  localparam int VPN_W      = 16;       // Everything above the page offset
  localparam int PPN_W      = 16;
  localparam int ASID_W     = 8;
  localparam int ROB_W      = 6;

  typedef logic [ADDR_W-1:0] address_t;
  typedef logic [VPN_W-1:0]  vpn_t;
  typedef logic [PPN_W-1:0]  ppn_t;
  typedef logic [ASID_W-1:0] asid_t;
  typedef logic [ROB_W-1:0]  rob_ndx_t;
  typedef logic [2:0]        rwx_t;     // Read, write and execute rights

  // One translation, 44 bits wide
  typedef struct packed {
    logic  valid;
    vpn_t  vpn;
    asid_t asid;
    ppn_t  ppn;
    rwx_t  rwx;
  } tlb_entry_t;

  // Which address-generation port produced a queued miss
  typedef enum logic {
    MISS_AGEN0,
    MISS_AGEN1
  } miss_src_e;

  // Reset fill machine
  typedef enum logic {
    FILL_RUN,
    FILL_DONE
  } fill_state_e;

  // ==========================================================================
  // Boot block placed at the top indices of way 0
  // ==========================================================================
  localparam int   BOOT_ENTRIES  = 12;
  localparam ppn_t BOOT_PPN_BASE = 16'hFFF4;
  localparam rwx_t BOOT_RWX_ROM  = 3'd5;   // Read and execute
  localparam rwx_t BOOT_RWX_IO   = 3'd6;   // Read and write
  localparam rwx_t BOOT_RWX_RAM  = 3'd7;   // Scratchpad, full access

endpackage

`default_nettype wire

// File: source/tlb_top.sv
`timescale 1ns/1ns
`default_nettype none

// Two-way TLB with two lookup ports, a software port and a miss queue
module tlb_top #(
  parameter int TLB_ENTRIES   = 128,
  parameter int MISSQ_ENTRIES = 16
) (
  input  logic                           clk,
  input  logic                           rst,
  output logic                           ready_o,
  // Software access
  input  logic                           wr_i,
  input  logic                           way_i,
  input  logic [$clog2(TLB_ENTRIES)-1:0] entry_no_i,
  input  tlb_pkg::tlb_entry_t            entry_i,
  output tlb_pkg::tlb_entry_t            rd_entry_o,
  // Lookup port 0
  input  logic                           agen0_v_i,
  input  tlb_pkg::address_t              agen0_vadr_i,
  input  tlb_pkg::asid_t                 agen0_asid_i,
  input  tlb_pkg::rob_ndx_t              agen0_rndx_i,
  input  logic                           stall_tlb0_i,
  output logic                           tlb0_v_o,
  output tlb_pkg::tlb_entry_t            tlb0_entry_o,
  output tlb_pkg::address_t              tlb0_vadr_o,
  output tlb_pkg::rob_ndx_t              tlb0_rndx_o,
  // Lookup port 1
  input  logic                           agen1_v_i,
  input  tlb_pkg::address_t              agen1_vadr_i,
  input  tlb_pkg::asid_t                 agen1_asid_i,
  input  tlb_pkg::rob_ndx_t              agen1_rndx_i,
  input  logic                           stall_tlb1_i,
  output logic                           tlb1_v_o,
  output tlb_pkg::tlb_entry_t            tlb1_entry_o,
  output tlb_pkg::address_t              tlb1_vadr_o,
  output tlb_pkg::rob_ndx_t              tlb1_rndx_o,
  // Walker side
  output logic                           miss_o,
  output tlb_pkg::miss_src_e             miss_src_o,
  output tlb_pkg::address_t              miss_vadr_o,
  output tlb_pkg::asid_t                 miss_asid_o,
  output tlb_pkg::rob_ndx_t              miss_rndx_o,
  input  logic                           missack_i
);
  import tlb_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRIES);

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] lk0_idx;
  logic [IDX_W-1:0] lk1_idx;
  tlb_entry_t       w0_rd, w0_lk0, w0_lk1;   // Way 0 read ports
  tlb_entry_t       w1_rd, w1_lk0, w1_lk1;   // Way 1 read ports

  tlb_wr_if #(.TLB_ENTRIES(TLB_ENTRIES)) wr_bus ();
  tlb_miss_if miss0_bus ();
  tlb_miss_if miss1_bus ();

  tlb_write_port #(.TLB_ENTRIES(TLB_ENTRIES)) u_wr_port (
    .clk, .rst, .wr_i, .way_i, .entry_no_i, .entry_i, .rd_entry_o,
    .way0_rd_i(w0_rd), .way1_rd_i(w1_rd), .rd_idx_o(rd_idx), .ready_o, .wr(wr_bus));

  tlb_way_ram #(.TLB_ENTRIES(TLB_ENTRIES), .WAY_ID(0)) u_way0 (
    .clk, .wr(wr_bus), .rd_idx_i(rd_idx), .lk0_idx_i(lk0_idx), .lk1_idx_i(lk1_idx),
    .rd_entry_o(w0_rd), .lk0_entry_o(w0_lk0), .lk1_entry_o(w0_lk1));

  tlb_way_ram #(.TLB_ENTRIES(TLB_ENTRIES), .WAY_ID(1)) u_way1 (
    .clk, .wr(wr_bus), .rd_idx_i(rd_idx), .lk0_idx_i(lk0_idx), .lk1_idx_i(lk1_idx),
    .rd_entry_o(w1_rd), .lk0_entry_o(w1_lk0), .lk1_entry_o(w1_lk1));

  tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_lookup0 (
    .clk, .rst, .v_i(agen0_v_i), .vadr_i(agen0_vadr_i), .asid_i(agen0_asid_i),
    .rndx_i(agen0_rndx_i), .stall_i(stall_tlb0_i), .idx_o(lk0_idx),
    .way0_entry_i(w0_lk0), .way1_entry_i(w1_lk0), .miss(miss0_bus),
    .v_o(tlb0_v_o), .entry_o(tlb0_entry_o), .vadr_o(tlb0_vadr_o), .rndx_o(tlb0_rndx_o));

  tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_lookup1 (
    .clk, .rst, .v_i(agen1_v_i), .vadr_i(agen1_vadr_i), .asid_i(agen1_asid_i),
    .rndx_i(agen1_rndx_i), .stall_i(stall_tlb1_i), .idx_o(lk1_idx),
    .way0_entry_i(w0_lk1), .way1_entry_i(w1_lk1), .miss(miss1_bus),
    .v_o(tlb1_v_o), .entry_o(tlb1_entry_o), .vadr_o(tlb1_vadr_o), .rndx_o(tlb1_rndx_o));

  // Misses are only queued once the fill has finished
  tlb_miss_queue #(.MISSQ_ENTRIES(MISSQ_ENTRIES)) u_missq (
    .clk, .rst, .ready_i(ready_o), .m0(miss0_bus), .m1(miss1_bus), .missack_i,
    .miss_o, .miss_src_o, .miss_vadr_o, .miss_asid_o, .miss_rndx_o);

endmodule

`default_nettype wire

// File: source/tlb_way_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Entry storage of one way. One synchronous write port shared by fill and
// software, three asynchronous reads for read-back and both lookups
module tlb_way_ram #(
  parameter int TLB_ENTRIES = 128,
  parameter int WAY_ID      = 0
) (
  input  logic                           clk,
  tlb_wr_if.ram                          wr,
  input  logic [$clog2(TLB_ENTRIES)-1:0] rd_idx_i,
  input  logic [$clog2(TLB_ENTRIES)-1:0] lk0_idx_i,
  input  logic [$clog2(TLB_ENTRIES)-1:0] lk1_idx_i,
  output tlb_pkg::tlb_entry_t            rd_entry_o,
  output tlb_pkg::tlb_entry_t            lk0_entry_o,
  output tlb_pkg::tlb_entry_t            lk1_entry_o
);
  import tlb_pkg::*;

  tlb_entry_t mem [TLB_ENTRIES];
  logic       sel;

  assign sel = wr.wr && (wr.way == 1'(WAY_ID));   // Write aimed at this way

  always_ff @(posedge clk) begin
    if (sel) mem[wr.idx] <= wr.entry;
  end

  // Distributed RAM style reads, no output register
  assign rd_entry_o  = mem[rd_idx_i];
  assign lk0_entry_o = mem[lk0_idx_i];
  assign lk1_entry_o = mem[lk1_idx_i];

  // The index bus may be wider than needed if the entry count is not a power of two
  a_idx_range: assert property (@(posedge clk) sel |-> (wr.idx < TLB_ENTRIES));

endmodule

`default_nettype wire

// File: source/tlb_wr_if.sv
`timescale 1ns/1ns
`default_nettype none

// Single entry write from the write port into the two way memories
interface tlb_wr_if #(parameter int TLB_ENTRIES = 128);
  import tlb_pkg::*;

  localparam int IDX_W = $clog2(TLB_ENTRIES);

  logic             wr;     // Write strobe for this cycle
  logic             way;    // Target way
  logic [IDX_W-1:0] idx;    // Set index
  tlb_entry_t       entry;  // Data to store

  modport src (output wr, way, idx, entry);
  modport ram (input wr, way, idx, entry);

endinterface

`default_nettype wire

// File: source/tlb_write_port.sv
`timescale 1ns/1ns
`default_nettype none

// Owns the way write bus. Clears the whole TLB after reset and loads the
// boot block, then forwards registered software writes
module tlb_write_port #(parameter int TLB_ENTRIES = 128) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wr_i,
  input  logic                           way_i,
  input  logic [$clog2(TLB_ENTRIES)-1:0] entry_no_i,
  input  tlb_pkg::tlb_entry_t            entry_i,
  output tlb_pkg::tlb_entry_t            rd_entry_o,
  input  tlb_pkg::tlb_entry_t            way0_rd_i,
  input  tlb_pkg::tlb_entry_t            way1_rd_i,
  output logic [$clog2(TLB_ENTRIES)-1:0] rd_idx_o,
  output logic                           ready_o,
  tlb_wr_if.src                          wr
);
  import tlb_pkg::*;

  localparam int IDX_W     = $clog2(TLB_ENTRIES);
  localparam int BOOT_BASE = TLB_ENTRIES - BOOT_ENTRIES;   // First boot index

  fill_state_e      state;
  logic [IDX_W:0]   fill_cnt;    // Way in bit 0, index above it
  logic             fill_way;
  logic [IDX_W-1:0] fill_idx;
  logic [IDX_W-1:0] boot_ofs;    // Position inside the boot block
  tlb_entry_t       fill_entry;
  logic             sw_wr;
  logic             sw_way;
  logic [IDX_W-1:0] sw_idx;
  tlb_entry_t       sw_entry;

  // ==========================================================================
  // Reset fill
  // ==========================================================================
  assign fill_way = fill_cnt[0];           // Alternate ways on each step
  assign fill_idx = fill_cnt[IDX_W:1];
  assign boot_ofs = fill_idx - IDX_W'(BOOT_BASE);

  always_comb begin
    fill_entry = '0;                       // Default is an invalid entry
    if (!fill_way && (fill_idx >= IDX_W'(BOOT_BASE))) begin
      fill_entry.valid = 1'b1;
      fill_entry.vpn   = {{(VPN_W-IDX_W){1'b1}}, fill_idx};   // Top of address space
      fill_entry.asid  = '0;               // Global to every address space
      fill_entry.ppn   = BOOT_PPN_BASE + PPN_W'(boot_ofs);
      // Groups of four pages: ROM, then IO, then scratchpad
      if (boot_ofs < IDX_W'(4))      fill_entry.rwx = BOOT_RWX_ROM;
      else if (boot_ofs < IDX_W'(8)) fill_entry.rwx = BOOT_RWX_IO;
      else                           fill_entry.rwx = BOOT_RWX_RAM;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= FILL_RUN;
      fill_cnt <= '0;
    end else if (state == FILL_RUN) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (&fill_cnt) state <= FILL_DONE;   // Last entry of way 1 written
    end
  end

  // ==========================================================================
  // Software path
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) sw_wr <= 1'b0;
    else     sw_wr <= wr_i && (state == FILL_DONE);   // Dropped while filling
  end

  always_ff @(posedge clk) begin
    sw_way   <= way_i;
    sw_idx   <= entry_no_i;
    sw_entry <= entry_i;
  end

  // The fill owns the bus until it is done
  assign wr.wr    = (state == FILL_RUN) ? 1'b1       : sw_wr;
  assign wr.way   = (state == FILL_RUN) ? fill_way   : sw_way;
  assign wr.idx   = (state == FILL_RUN) ? fill_idx   : sw_idx;
  assign wr.entry = (state == FILL_RUN) ? fill_entry : sw_entry;

  assign rd_idx_o   = entry_no_i;                        // Read-back is combinational
  assign rd_entry_o = way_i ? way1_rd_i : way0_rd_i;
  assign ready_o    = (state == FILL_DONE);

  a_no_sw_in_fill: assert property (@(posedge clk) disable iff (rst)
    (state == FILL_RUN) |-> !sw_wr);

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Free running clock and a synchronous reset held for a fixed number of edges
module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;                       // Released just after an edge like every other input
  end

endmodule

`default_nettype wire

// File: verif/tb_tlb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tlb;
  import tlb_pkg::*;

  localparam int TLB_ENTRIES   = 128;
  localparam int MISSQ_ENTRIES = 16;
  localparam int IDX_W         = $clog2(TLB_ENTRIES);
  localparam int BOOT_BASE     = TLB_ENTRIES - BOOT_ENTRIES;
  localparam int N_TESTS       = 6;
  localparam int RST_CYCLES    = 10;
  localparam int CLK_NS        = 4;
  // Reset and fill, then a fixed allowance for every test
  localparam int WATCHDOG_NS   = (RST_CYCLES + 2 * TLB_ENTRIES + 200 * N_TESTS) * CLK_NS;

  // One waiting miss as the walker should see it
  typedef struct packed {
    miss_src_e src;
    address_t  vadr;
    asid_t     asid;
    rob_ndx_t  rndx;
  } mq_t;

  logic             clk, rst, ready_o;
  logic             wr_i, way_i;
  logic [IDX_W-1:0] entry_no_i;
  tlb_entry_t       entry_i, rd_entry_o;
  logic             agen0_v_i, agen1_v_i, stall_tlb0_i, stall_tlb1_i;
  address_t         agen0_vadr_i, agen1_vadr_i;
  asid_t            agen0_asid_i, agen1_asid_i;
  rob_ndx_t         agen0_rndx_i, agen1_rndx_i;
  logic             tlb0_v_o, tlb1_v_o;
  tlb_entry_t       tlb0_entry_o, tlb1_entry_o;
  address_t         tlb0_vadr_o, tlb1_vadr_o;
  rob_ndx_t         tlb0_rndx_o, tlb1_rndx_o;
  logic             miss_o, missack_i;
  miss_src_e        miss_src_o;
  address_t         miss_vadr_o;
  asid_t            miss_asid_o;
  rob_ndx_t         miss_rndx_o;

  // Reference model state, advanced once per cycle by the compare process
  tlb_entry_t  sh0 [TLB_ENTRIES];       // Shadow of way 0
  tlb_entry_t  sh1 [TLB_ENTRIES];       // Shadow of way 1
  mq_t         exp_q [$];               // Expected queue contents, head first
  logic        exp_v [2];
  tlb_entry_t  exp_e [2];
  address_t    exp_va [2];
  rob_ndx_t    exp_rn [2];
  int          fill_left;               // Edges until ready_o should rise
  logic        pend_wr;                 // Software write sitting in the register stage
  logic        pend_way;
  int          pend_idx;
  tlb_entry_t  pend_e;
  logic [31:0] rng = 32'd83;
  int          errors = 0;
  int          checks = 0;
  int          err_mark = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(RST_CYCLES)) clk_gen_i (.clk, .rst);

  tlb_top #(.TLB_ENTRIES(TLB_ENTRIES), .MISSQ_ENTRIES(MISSQ_ENTRIES)) dut_i (.*);

  // ==========================================================================
  // Random numbers and reference functions
  // ==========================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rnd();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Asids with the top bit set are never written, so these pages always miss
  function automatic asid_t miss_asid();
    return asid_t'(rnd() | 32'h80);
  endfunction

  // Content of an entry once the reset fill has passed it
  function automatic tlb_entry_t fill_rule(input int way, input int idx);
    tlb_entry_t e;
    int         ofs;
    e   = '0;
    ofs = idx - BOOT_BASE;
    if (way == 0 && ofs >= 0) begin
      e.valid = 1'b1;
      e.vpn   = vpn_t'(2 ** VPN_W - 2 ** IDX_W + idx);   // Ones above the index bits
      e.ppn   = BOOT_PPN_BASE + ppn_t'(ofs);
      e.rwx   = (ofs < 4) ? BOOT_RWX_ROM : (ofs < 8) ? BOOT_RWX_IO : BOOT_RWX_RAM;
    end
    return e;
  endfunction

  // Expected lookup result, way 0 first
  function automatic logic lookup_ref(input address_t va, input asid_t as,
                                      output tlb_entry_t e);
    int         idx;
    vpn_t       vpn;
    logic       h0;
    logic       h1;
    idx = int'(va[PAGE_SHIFT +: IDX_W]);
    vpn = va[ADDR_W-1:PAGE_SHIFT];
    h0  = sh0[idx].valid && (sh0[idx].vpn == vpn) && (sh0[idx].asid == as);
    h1  = sh1[idx].valid && (sh1[idx].vpn == vpn) && (sh1[idx].asid == as);
    e   = h0 ? sh0[idx] : sh1[idx];
    return h0 || h1;
  endfunction

  function automatic logic queued(input address_t va, input asid_t as);
    foreach (exp_q[i])
      if (exp_q[i].vadr[ADDR_W-1:PAGE_SHIFT] == va[ADDR_W-1:PAGE_SHIFT] && exp_q[i].asid == as)
        return 1'b1;
    return 1'b0;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_port(input int n, input logic v, input tlb_entry_t e,
                            input address_t va, input rob_ndx_t rn);
    check_val($sformatf("tlb%0d_v_o", n), 64'(v), 64'(exp_v[n]));
    if (exp_v[n]) begin
      check_val($sformatf("tlb%0d_entry_o", n), 64'(e), 64'(exp_e[n]));
      check_val($sformatf("tlb%0d_vadr_o", n), 64'(va), 64'(exp_va[n]));
      check_val($sformatf("tlb%0d_rndx_o", n), 64'(rn), 64'(exp_rn[n]));
    end
  endtask

  // ==========================================================================
  // Compare process, mid-cycle when outputs and inputs are both settled
  // ==========================================================================
  always @(negedge clk) begin : compare
    tlb_entry_t e0;
    tlb_entry_t e1;
    tlb_entry_t rb;
    logic       t0, t1, h0, h1, miss0, miss1, room, same, en0, en1;
    if (rst) begin
      fill_left = 2 * TLB_ENTRIES;      // One entry of one way per edge
      exp_v[0]  = 1'b0;
      exp_v[1]  = 1'b0;
      pend_wr   = 1'b0;
      exp_q.delete();
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        sh0[i] = fill_rule(0, i);
        sh1[i] = fill_rule(1, i);
      end
    end else begin
      check_val("ready_o", 64'(ready_o), 64'(fill_left == 0));
      check_port(0, tlb0_v_o, tlb0_entry_o, tlb0_vadr_o, tlb0_rndx_o);
      check_port(1, tlb1_v_o, tlb1_entry_o, tlb1_vadr_o, tlb1_rndx_o);
      check_val("miss_o", 64'(miss_o), 64'(exp_q.size() != 0));
      if (exp_q.size() != 0) begin    // Head of the queue is on the walker outputs
        check_val("miss_src_o", 64'(miss_src_o), 64'(exp_q[0].src));
        check_val("miss_vadr_o", 64'(miss_vadr_o), 64'(exp_q[0].vadr));
        check_val("miss_asid_o", 64'(miss_asid_o), 64'(exp_q[0].asid));
        check_val("miss_rndx_o", 64'(miss_rndx_o), 64'(exp_q[0].rndx));
      end
      if (fill_left == 0) begin
        rb = way_i ? sh1[entry_no_i] : sh0[entry_no_i];
        check_val("rd_entry_o", 64'(rd_entry_o), 64'(rb));
      end

      // Lookups sampled at the coming edge see memory before the pending write
      t0       = agen0_v_i && !stall_tlb0_i;
      t1       = agen1_v_i && !stall_tlb1_i;
      h0       = lookup_ref(agen0_vadr_i, agen0_asid_i, e0);
      h1       = lookup_ref(agen1_vadr_i, agen1_asid_i, e1);
      exp_v[0] = t0 && h0;
      exp_v[1] = t1 && h1;
      if (exp_v[0]) begin
        exp_e[0]  = e0;
        exp_va[0] = agen0_vadr_i;
        exp_rn[0] = agen0_rndx_i;
      end
      if (exp_v[1]) begin
        exp_e[1]  = e1;
        exp_va[1] = agen1_vadr_i;
        exp_rn[1] = agen1_rndx_i;
      end

      miss0 = t0 && !h0;
      miss1 = t1 && !h1;
      // Capacity is one below the slot count, and two places must stay free
      room  = (fill_left == 0) && (MISSQ_ENTRIES - 1 - exp_q.size() >= 2);
      same  = miss0 && (agen0_asid_i == agen1_asid_i) &&
              (agen0_vadr_i[ADDR_W-1:PAGE_SHIFT] == agen1_vadr_i[ADDR_W-1:PAGE_SHIFT]);
      en0   = room && miss0 && !queued(agen0_vadr_i, agen0_asid_i);
      en1   = room && miss1 && !queued(agen1_vadr_i, agen1_asid_i) && !same;
      if (missack_i && exp_q.size() != 0) void'(exp_q.pop_front());
      if (en0) exp_q.push_back(mq_t'({MISS_AGEN0, agen0_vadr_i, agen0_asid_i, agen0_rndx_i}));
      if (en1) exp_q.push_back(mq_t'({MISS_AGEN1, agen1_vadr_i, agen1_asid_i, agen1_rndx_i}));

      if (pend_wr) begin                // Lands in the way at the coming edge
        if (pend_way) sh1[pend_idx] = pend_e;
        else          sh0[pend_idx] = pend_e;
      end
      pend_wr  = (fill_left == 0) && wr_i;   // Ignored while the fill runs
      pend_way = way_i;
      pend_idx = int'(entry_no_i);
      pend_e   = entry_i;
      if (fill_left > 0) fill_left--;
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic test_done(input int num, input string name);
    $display("test %0d %s finished with %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  // One cycle of lookups on both ports, then both requests drop
  task automatic drive_pair(input logic v0, input address_t va0, input asid_t as0,
                            input logic v1, input address_t va1, input asid_t as1);
    agen0_v_i    = v0;
    agen0_vadr_i = va0;
    agen0_asid_i = as0;
    agen0_rndx_i = rob_ndx_t'(rnd());
    agen1_v_i    = v1;
    agen1_vadr_i = va1;
    agen1_asid_i = as1;
    agen1_rndx_i = rob_ndx_t'(rnd());
    step();
    agen0_v_i = 1'b0;
    agen1_v_i = 1'b0;
  endtask

  task automatic sw_write(input logic way, input int idx, input tlb_entry_t e);
    wr_i       = 1'b1;
    way_i      = way;
    entry_no_i = IDX_W'(idx);
    entry_i    = e;
    step();
    wr_i = 1'b0;
  endtask

  // Walker side, pops one miss per cycle until the queue is empty
  task automatic ack_all();
    while (miss_o === 1'b1) begin
      missack_i = 1'b1;
      step();
    end
    missack_i = 1'b0;
  endtask

  initial begin : stimulus
    address_t    va0, va1, va2, va3;
    asid_t       as0, as1, as2, as3;
    tlb_entry_t  e;
    tlb_entry_t  e2;
    int          idx;
    logic [31:0] r;
    wr_i         = 1'b0;
    way_i        = 1'b0;
    entry_no_i   = '0;
    entry_i      = '0;
    agen0_v_i    = 1'b0;
    agen0_vadr_i = '0;
    agen0_asid_i = '0;
    agen0_rndx_i = '0;
    agen1_v_i    = 1'b0;
    agen1_vadr_i = '0;
    agen1_asid_i = '0;
    agen1_rndx_i = '0;
    stall_tlb0_i = 1'b0;
    stall_tlb1_i = 1'b0;
    missack_i    = 1'b0;
    step();
    while (ready_o !== 1'b1) step();   // Reset, then the fill walks every entry

    // 1. Read back both ways, compared against the fill rule every cycle
    for (int w = 0; w < 2; w++) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        way_i      = w[0];
        entry_no_i = IDX_W'(i);
        step();
      end
    end
    test_done(1, "boot fill");

    // 2. Boot pages from both ends of the block on both ports at once
    for (int i = 0; i < BOOT_ENTRIES; i++) begin
      va0 = {sh0[BOOT_BASE + i].vpn, PAGE_SHIFT'(rnd())};
      va1 = {sh0[TLB_ENTRIES - 1 - i].vpn, PAGE_SHIFT'(rnd())};
      drive_pair(1'b1, va0, '0, 1'b1, va1, '0);
    end
    step();
    step();
    test_done(2, "lookup hit");

    // 3. Random entries below the boot block, every other one doubled in both ways
    for (int n = 0; n < 8; n++) begin
      idx     = int'(rnd() % BOOT_BASE);
      r       = rnd();
      e.valid = 1'b1;
      e.vpn   = vpn_t'((rnd() << IDX_W) | idx);   // Index bits must match the set
      e.asid  = asid_t'(rnd() & 32'h7F);
      e.ppn   = ppn_t'(rnd());
      e.rwx   = rwx_t'(rnd());
      sw_write(r[0], idx, e);
      if (n % 2 == 0) begin
        e2     = e;
        e2.ppn = ~e.ppn;
        sw_write(!r[0], idx, e2);
      end
      step();                             // Written into the way one edge after the register
      va0 = {e.vpn, PAGE_SHIFT'(rnd())};
      drive_pair(1'b1, va0, e.asid, 1'b1, va0, e.asid);
    end
    step();
    step();
    test_done(3, "software write");

    // 4. Queue order, repeated page and a tie between the ports
    // Port 0 starts on page zero, which matches a cleared entry in all but its valid bit
    va0 = {VPN_W'(0), PAGE_SHIFT'(rnd())};
    as0 = '0;
    // Port 1 starts on a boot index whose upper page bits differ from the boot page
    va1 = {1'b0, sh0[BOOT_BASE].vpn[VPN_W-2:0], PAGE_SHIFT'(rnd())};
    as1 = '0;
    va2 = rnd();
    as2 = miss_asid();
    va3 = rnd();
    as3 = miss_asid();
    drive_pair(1'b1, va0, as0, 1'b1, va1, as1);
    // Port 0 page is already waiting, seen here at another offset
    drive_pair(1'b1, {va0[ADDR_W-1:PAGE_SHIFT], PAGE_SHIFT'(rnd())}, as0, 1'b1, va2, as2);
    drive_pair(1'b1, va3, as3, 1'b1, {va3[ADDR_W-1:PAGE_SHIFT], PAGE_SHIFT'(rnd())}, as3);
    step();
    ack_all();
    step();
    test_done(4, "miss queue");

    // 5. Held requests, a hit on port 0 and a miss on port 1
    agen0_v_i    = 1'b1;
    agen0_vadr_i = {sh0[BOOT_BASE].vpn, PAGE_SHIFT'(rnd())};
    agen0_asid_i = '0;
    agen1_v_i    = 1'b1;
    agen1_vadr_i = rnd();
    agen1_asid_i = miss_asid();
    stall_tlb0_i = 1'b1;
    stall_tlb1_i = 1'b1;
    repeat (3) step();
    for (int n = 0; n < 6; n++) begin
      r            = rnd();
      stall_tlb0_i = r[0];
      stall_tlb1_i = r[1];
      step();
    end
    stall_tlb0_i = 1'b0;
    stall_tlb1_i = 1'b0;
    step();
    agen0_v_i = 1'b0;
    agen1_v_i = 1'b0;
    step();
    ack_all();
    step();
    test_done(5, "stall");

    // 6. Overfill without the walker, then retry the last pair while popping
    for (int n = 0; n < MISSQ_ENTRIES; n++)
      drive_pair(1'b1, rnd(), miss_asid(), 1'b1, rnd(), miss_asid());
    agen0_v_i = 1'b1;
    agen1_v_i = 1'b1;
    missack_i = 1'b1;
    repeat (4) step();
    missack_i = 1'b0;
    agen0_v_i = 1'b0;
    agen1_v_i = 1'b0;
    step();
    ack_all();
    step();
    test_done(6, "queue full");

    repeat (3) step();
    $display("%0d tests run, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
